/* hdl/arena_pkg.sv */
package arena_pkg;

	////////////////////////////////////////
	// video timing, 640x480 with 25 MHz pixel clock
	////////////////////////////////////////
	localparam int H_TOTAL     = 800; // pixels per line, blanking included
	localparam int V_TOTAL     = 521; // lines per frame
	localparam int H_PULSE     = 96;  // hsync low width in pixels
	localparam int V_PULSE     = 2;   // vsync low width in lines
	localparam int H_ACT_START = 144; // end of horizontal back porch
	localparam int V_ACT_START = 31;  // end of vertical back porch
	localparam int ACT_W       = 640;
	localparam int ACT_H       = 480;

	////////////////////////////////////////
	// playfield grid
	////////////////////////////////////////
	localparam int GRID_DIM   = 10;                   // cells per side
	localparam int CELL_W     = 64;                   // ACT_W / GRID_DIM
	localparam int CELL_H     = 48;                   // ACT_H / GRID_DIM
	localparam int GRID_CELLS = GRID_DIM * GRID_DIM;  // bits in each flat vector
	localparam int GRID_IDX_W = $clog2(GRID_CELLS);   // flat index row*10+col

	// 3-3-2 colour output
	localparam int RED_W   = 3;
	localparam int GREEN_W = 3;
	localparam int BLUE_W  = 2;

	typedef logic [9:0] coord_t;    // h or v counter
	typedef logic [3:0] cell_idx_t; // grid row or column
	typedef logic [5:0] col_off_t;  // 0..63 inside a cell
	typedef logic [5:0] row_off_t;  // 0..47 inside a cell
	typedef logic [1:0] bomb_lvl_t; // 0 means no bomb

	// brick mortar lines, same count in both directions
	localparam int MORTAR_CNT = 6;
	localparam col_off_t [0:MORTAR_CNT-1] MORTAR_COLS =
		'{6'd0, 6'd13, 6'd26, 6'd39, 6'd52, 6'd63};
	localparam row_off_t [0:MORTAR_CNT-1] MORTAR_ROWS =
		'{6'd0, 6'd9, 6'd19, 6'd29, 6'd39, 6'd47};

	// what a pixel shows, decided before colour lookup
	typedef enum logic [3:0] {
		PIX_BLANK,      // outside active window
		PIX_BACKGROUND, // empty cell
		PIX_BOMB1,
		PIX_BOMB2,
		PIX_BOMB3,
		PIX_PLAYER1,
		PIX_PLAYER2,
		PIX_BRICK,      // block cell body
		PIX_MORTAR      // block cell joint lines
	} pix_class_e;

endpackage

/* hdl/vga_sync_gen.sv */
`timescale 1ns/1ps

module vga_sync_gen #(
	parameter int H_TOTAL = arena_pkg::H_TOTAL, // pixels per line
	parameter int V_TOTAL = arena_pkg::V_TOTAL, // lines per frame
	parameter int H_PULSE = arena_pkg::H_PULSE,
	parameter int V_PULSE = arena_pkg::V_PULSE
) (
	input  logic              pixel_clk,
	input  logic              rst,
	output arena_pkg::coord_t h_count_o, // current pixel in line
	output arena_pkg::coord_t v_count_o, // current line in frame
	output logic              hsync_o,   // raw, not yet aligned to pixel data
	output logic              vsync_o
);

	import arena_pkg::*;

	coord_t h_cnt;
	coord_t v_cnt;
	logic   h_end; // last pixel of the line
	logic   v_end; // last line of the frame

	assign h_end = (h_cnt == coord_t'(H_TOTAL - 1));
	assign v_end = (v_cnt == coord_t'(V_TOTAL - 1));

	////////////////////////////////////////
	// line and frame counters
	////////////////////////////////////////
	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_end) begin
				h_cnt <= '0; // wrap, next line
				if (v_end) begin
					v_cnt <= '0; // new frame
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	assign h_count_o = h_cnt;
	assign v_count_o = v_cnt;

	// syncs are active low at the start of line / frame
	assign hsync_o = (h_cnt >= coord_t'(H_PULSE));
	assign vsync_o = (v_cnt >= coord_t'(V_PULSE));

endmodule

/* hdl/grid_locator.sv */
`timescale 1ns/1ps

module grid_locator #(
	parameter int H_ACT_START = arena_pkg::H_ACT_START, // first active column
	parameter int V_ACT_START = arena_pkg::V_ACT_START, // first active line
	parameter int ACT_W       = arena_pkg::ACT_W,
	parameter int ACT_H       = arena_pkg::ACT_H
) (
	input  logic                 pixel_clk,
	input  logic                 rst,
	input  arena_pkg::coord_t    h_count_i,
	input  arena_pkg::coord_t    v_count_i,
	input  logic                 hsync_i,
	input  logic                 vsync_i,
	output logic                 active_o,  // pixel is inside the 640x480 window
	output arena_pkg::cell_idx_t row_o,     // grid row, counts down the screen
	output arena_pkg::cell_idx_t col_o,     // grid column, counts across
	output arena_pkg::row_off_t  row_off_o, // line within the cell
	output arena_pkg::col_off_t  col_off_o, // pixel within the cell
	output logic                 hsync_o,
	output logic                 vsync_o
);

	import arena_pkg::*;

	// window bounds, start inclusive, end exclusive
	localparam coord_t H_BEG = coord_t'(H_ACT_START);
	localparam coord_t H_END = coord_t'(H_ACT_START + ACT_W);
	localparam coord_t V_BEG = coord_t'(V_ACT_START);
	localparam coord_t V_END = coord_t'(V_ACT_START + ACT_H);

	logic      in_win;
	coord_t    h_norm;   // window relative x
	coord_t    v_norm;   // window relative y
	cell_idx_t row_next;
	cell_idx_t col_next;
	row_off_t  row_off_next;
	col_off_t  col_off_next;

	assign in_win = (h_count_i >= H_BEG) && (h_count_i < H_END) &&
		(v_count_i >= V_BEG) && (v_count_i < V_END);

	assign h_norm = h_count_i - H_BEG;
	assign v_norm = v_count_i - V_BEG;

	////////////////////////////////////////
	// split into cell index and offset
	////////////////////////////////////////
	always_comb begin
		if (in_win) begin
			col_next     = cell_idx_t'(h_norm / CELL_W); // 64 wide, a plain shift
			col_off_next = col_off_t'(h_norm % CELL_W);
			row_next     = cell_idx_t'(v_norm / CELL_H); // 48 high, constant divide
			row_off_next = row_off_t'(v_norm % CELL_H);
		end else begin
			// keep cell fields in range while blanked
			col_next     = '0;
			col_off_next = '0;
			row_next     = '0;
			row_off_next = '0;
		end
	end

	// stage 1 control
	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			active_o <= 1'b0;
			hsync_o  <= 1'b1; // idle high
			vsync_o  <= 1'b1;
		end else begin
			active_o <= in_win;
			hsync_o  <= hsync_i;
			vsync_o  <= vsync_i;
		end
	end

	// stage 1 payload
	always_ff @(posedge pixel_clk) begin
		row_o     <= row_next;
		col_o     <= col_next;
		row_off_o <= row_off_next;
		col_off_o <= col_off_next;
	end

endmodule

/* hdl/tile_classifier.sv */
`timescale 1ns/1ps

module tile_classifier (
	input  logic                                pixel_clk,
	input  logic                                rst,
	input  logic                                active_i,
	input  arena_pkg::cell_idx_t                row_i,
	input  arena_pkg::cell_idx_t                col_i,
	input  arena_pkg::row_off_t                 row_off_i,
	input  arena_pkg::col_off_t                 col_off_i,
	input  logic                                hsync_i,
	input  logic                                vsync_i,
	input  logic [arena_pkg::GRID_CELLS-1:0]    arena_i,     // 1 = block
	input  logic [arena_pkg::GRID_CELLS-1:0]    bomb_bit0_i, // bomb level lsb
	input  logic [arena_pkg::GRID_CELLS-1:0]    bomb_bit1_i, // bomb level msb
	input  arena_pkg::cell_idx_t                player1_row_i,
	input  arena_pkg::cell_idx_t                player1_col_i,
	input  arena_pkg::cell_idx_t                player2_row_i,
	input  arena_pkg::cell_idx_t                player2_col_i,
	output arena_pkg::pix_class_e               pix_class_o,
	output logic                                hsync_o,
	output logic                                vsync_o
);

	import arena_pkg::*;

	logic [GRID_IDX_W-1:0] cell_idx;   // row*10 + col
	logic                  cell_block; // arena bit of this cell
	bomb_lvl_t             cell_bomb;
	logic                  on_p1;
	logic                  on_p2;
	logic                  mortar_hit; // on a joint line of a brick cell
	pix_class_e            class_next;

	////////////////////////////////////////
	// cell state lookup
	////////////////////////////////////////
	assign cell_idx   = GRID_IDX_W'(row_i * GRID_DIM + col_i);
	assign cell_block = arena_i[cell_idx];
	assign cell_bomb  = {bomb_bit1_i[cell_idx], bomb_bit0_i[cell_idx]};

	// player positions compare against the whole cell
	assign on_p1 = (row_i == player1_row_i) && (col_i == player1_col_i);
	assign on_p2 = (row_i == player2_row_i) && (col_i == player2_col_i);

	// mortar is any listed column offset or any listed row offset
	always_comb begin
		mortar_hit = 1'b0;
		for (int i = 0; i < MORTAR_CNT; i++) begin
			if (col_off_i == MORTAR_COLS[i]) begin
				mortar_hit = 1'b1; // vertical joint
			end
			if (row_off_i == MORTAR_ROWS[i]) begin
				mortar_hit = 1'b1; // horizontal joint
			end
		end
	end

	////////////////////////////////////////
	// priority, first match wins
	////////////////////////////////////////
	always_comb begin
		if (!active_i) begin
			class_next = PIX_BLANK; // porch or sync
		end else if (on_p1) begin
			class_next = PIX_PLAYER1; // player 1 above everything, even player 2
		end else if (on_p2) begin
			class_next = PIX_PLAYER2;
		end else if (cell_block) begin
			class_next = mortar_hit ? PIX_MORTAR : PIX_BRICK;
		end else begin
			case (cell_bomb)
				2'd1:    class_next = PIX_BOMB1; // freshly placed
				2'd2:    class_next = PIX_BOMB2;
				2'd3:    class_next = PIX_BOMB3; // about to go off
				default: class_next = PIX_BACKGROUND;
			endcase
		end
	end

	// stage 2 register, syncs follow along
	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			pix_class_o <= PIX_BLANK;
			hsync_o     <= 1'b1;
			vsync_o     <= 1'b1;
		end else begin
			pix_class_o <= class_next;
			hsync_o     <= hsync_i;
			vsync_o     <= vsync_i;
		end
	end

endmodule

/* hdl/color_palette.sv */
`timescale 1ns/1ps

module color_palette (
	input  logic                         pixel_clk,
	input  logic                         rst,
	input  arena_pkg::pix_class_e        pix_class_i,
	input  logic                         hsync_i,
	input  logic                         vsync_i,
	output logic [arena_pkg::RED_W-1:0]  red_o,
	output logic [arena_pkg::GREEN_W-1:0] green_o,
	output logic [arena_pkg::BLUE_W-1:0] blue_o,
	output logic                         hsync_o, // to the connector
	output logic                         vsync_o
);

	import arena_pkg::*;

	logic [RED_W-1:0]   red_next;
	logic [GREEN_W-1:0] green_next;
	logic [BLUE_W-1:0]  blue_next;

	////////////////////////////////////////
	// class to 3-3-2 colour
	////////////////////////////////////////
	always_comb begin
		case (pix_class_i)
			PIX_BACKGROUND: {red_next, green_next, blue_next} = {3'b111, 3'b111, 2'b11}; // white
			PIX_BOMB1:      {red_next, green_next, blue_next} = {3'b101, 3'b001, 2'b11};
			PIX_BOMB2:      {red_next, green_next, blue_next} = {3'b100, 3'b000, 2'b11};
			PIX_BOMB3:      {red_next, green_next, blue_next} = {3'b111, 3'b000, 2'b00}; // red
			PIX_PLAYER1:    {red_next, green_next, blue_next} = {3'b000, 3'b111, 2'b00}; // green
			PIX_PLAYER2:    {red_next, green_next, blue_next} = {3'b000, 3'b000, 2'b11}; // blue
			PIX_BRICK:      {red_next, green_next, blue_next} = {3'b110, 3'b010, 2'b00};
			PIX_MORTAR:     {red_next, green_next, blue_next} = {3'b000, 3'b000, 2'b00};
			default:        {red_next, green_next, blue_next} = '0; // blank is black
		endcase
	end

	// stage 3, final output flops
	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			red_o   <= '0;
			green_o <= '0;
			blue_o  <= '0;
			hsync_o <= 1'b1;
			vsync_o <= 1'b1;
		end else begin
			red_o   <= red_next;
			green_o <= green_next;
			blue_o  <= blue_next;
			hsync_o <= hsync_i; // now aligned with rgb
			vsync_o <= vsync_i;
		end
	end

endmodule

/* hdl/arena_display.sv */
`timescale 1ns/1ps

module arena_display #(
	parameter int H_TOTAL     = arena_pkg::H_TOTAL,
	parameter int V_TOTAL     = arena_pkg::V_TOTAL,
	parameter int H_PULSE     = arena_pkg::H_PULSE,
	parameter int V_PULSE     = arena_pkg::V_PULSE,
	parameter int H_ACT_START = arena_pkg::H_ACT_START,
	parameter int V_ACT_START = arena_pkg::V_ACT_START,
	parameter int ACT_W       = arena_pkg::ACT_W,
	parameter int ACT_H       = arena_pkg::ACT_H
) (
	input  logic                             pixel_clk, // 25 MHz
	input  logic                             rst,
	input  logic [arena_pkg::GRID_CELLS-1:0] arena_i,
	input  logic [arena_pkg::GRID_CELLS-1:0] bomb_bit0_i,
	input  logic [arena_pkg::GRID_CELLS-1:0] bomb_bit1_i,
	input  arena_pkg::cell_idx_t             player1_row_i,
	input  arena_pkg::cell_idx_t             player1_col_i,
	input  arena_pkg::cell_idx_t             player2_row_i,
	input  arena_pkg::cell_idx_t             player2_col_i,
	output logic                             hsync_o,
	output logic                             vsync_o,
	output logic [arena_pkg::RED_W-1:0]      red_o,
	output logic [arena_pkg::GREEN_W-1:0]    green_o,
	output logic [arena_pkg::BLUE_W-1:0]     blue_o
);

	import arena_pkg::*;

	// counters and raw syncs
	coord_t     h_count;
	coord_t     v_count;
	logic       hsync_raw;
	logic       vsync_raw;

	// after locator
	logic       loc_active;
	cell_idx_t  loc_row;
	cell_idx_t  loc_col;
	row_off_t   loc_row_off;
	col_off_t   loc_col_off;
	logic       loc_hsync;
	logic       loc_vsync;

	// after classifier
	pix_class_e pix_class;
	logic       cls_hsync;
	logic       cls_vsync;

	////////////////////////////////////////
	// counters -> locate -> classify -> colour, 3 cycles
	////////////////////////////////////////
	vga_sync_gen #(
		.H_TOTAL (H_TOTAL),
		.V_TOTAL (V_TOTAL),
		.H_PULSE (H_PULSE),
		.V_PULSE (V_PULSE)
	) sync_gen_inst (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.h_count_o (h_count),
		.v_count_o (v_count),
		.hsync_o   (hsync_raw),
		.vsync_o   (vsync_raw)
	);

	grid_locator #(
		.H_ACT_START (H_ACT_START),
		.V_ACT_START (V_ACT_START),
		.ACT_W       (ACT_W),
		.ACT_H       (ACT_H)
	) locator_inst (
		.pixel_clk (pixel_clk),
		.rst       (rst),
		.h_count_i (h_count),
		.v_count_i (v_count),
		.hsync_i   (hsync_raw),
		.vsync_i   (vsync_raw),
		.active_o  (loc_active),
		.row_o     (loc_row),
		.col_o     (loc_col),
		.row_off_o (loc_row_off),
		.col_off_o (loc_col_off),
		.hsync_o   (loc_hsync),
		.vsync_o   (loc_vsync)
	);

	tile_classifier classifier_inst (
		.pixel_clk     (pixel_clk),
		.rst           (rst),
		.active_i      (loc_active),
		.row_i         (loc_row),
		.col_i         (loc_col),
		.row_off_i     (loc_row_off),
		.col_off_i     (loc_col_off),
		.hsync_i       (loc_hsync),
		.vsync_i       (loc_vsync),
		.arena_i       (arena_i),
		.bomb_bit0_i   (bomb_bit0_i),
		.bomb_bit1_i   (bomb_bit1_i),
		.player1_row_i (player1_row_i),
		.player1_col_i (player1_col_i),
		.player2_row_i (player2_row_i),
		.player2_col_i (player2_col_i),
		.pix_class_o   (pix_class),
		.hsync_o       (cls_hsync),
		.vsync_o       (cls_vsync)
	);

	color_palette palette_inst (
		.pixel_clk   (pixel_clk),
		.rst         (rst),
		.pix_class_i (pix_class),
		.hsync_i     (cls_hsync),
		.vsync_i     (cls_vsync),
		.red_o       (red_o),
		.green_o     (green_o),
		.blue_o      (blue_o),
		.hsync_o     (hsync_o),
		.vsync_o     (vsync_o)
	);

endmodule

/* dv/arena_display_assertions.sv */
`timescale 1ns/1ps

module arena_display_assertions (
	input logic       pixel_clk,
	input logic       rst,
	input logic       hsync_i,
	input logic       vsync_i,
	input logic [2:0] red_i,
	input logic [2:0] green_i,
	input logic [1:0] blue_i
);

	logic [9:0]  h_low;   // consecutive low cycles of hsync
	logic [10:0] h_since; // cycles since the last hsync fall
	logic [10:0] v_low;   // 1600 needs 11 bits
	logic [18:0] v_since; // one frame is 416800 cycles
	logic        h_seen;  // a first hsync fall has happened
	logic        v_seen;
	logic        hsync_q;
	logic        vsync_q;
	int          fail_count = 0; // assertion failures so far

	////////////////////////////////////////
	// pulse and period counters
	////////////////////////////////////////
	always_ff @(posedge pixel_clk or posedge rst) begin
		if (rst) begin
			h_low   <= '0;
			h_since <= '0;
			v_low   <= '0;
			v_since <= '0;
			h_seen  <= 1'b0;
			v_seen  <= 1'b0;
			hsync_q <= 1'b1; // syncs idle high
			vsync_q <= 1'b1;
		end else begin
			hsync_q <= hsync_i;
			vsync_q <= vsync_i;
			h_low   <= hsync_i ? '0 : h_low + 1'b1;
			v_low   <= vsync_i ? '0 : v_low + 1'b1;
			if (hsync_q && !hsync_i) begin
				h_since <= 11'd1; // restart at each line
				h_seen  <= 1'b1;
			end else begin
				h_since <= h_since + 1'b1;
			end
			if (vsync_q && !vsync_i) begin
				v_since <= 19'd1; // restart at each frame
				v_seen  <= 1'b1;
			end else begin
				v_since <= v_since + 1'b1;
			end
		end
	end

	// 96 pixels low, 800 per line
	hsync_width: assert property (@(posedge pixel_clk) disable iff (rst)
		$rose(hsync_i) |-> h_low == 10'd96)
		else begin
			$error("hsync_o low pulse is not 96 cycles wide");
			fail_count++;
		end
	hsync_period: assert property (@(posedge pixel_clk) disable iff (rst)
		$fell(hsync_i) && h_seen |-> h_since == 11'd800)
		else begin
			$error("hsync_o period is not 800 cycles");
			fail_count++;
		end

	// two lines low, 521 lines per frame
	vsync_width: assert property (@(posedge pixel_clk) disable iff (rst)
		$rose(vsync_i) |-> v_low == 11'd1600)
		else begin
			$error("vsync_o low pulse is not 1600 cycles wide");
			fail_count++;
		end
	vsync_period: assert property (@(posedge pixel_clk) disable iff (rst)
		$fell(vsync_i) && v_seen |-> v_since == 19'd416800)
		else begin
			$error("vsync_o period is not 416800 cycles");
			fail_count++;
		end

	// frame starts on a line start
	vsync_on_line_start: assert property (@(posedge pixel_clk) disable iff (rst)
		$fell(vsync_i) |-> $fell(hsync_i))
		else begin
			$error("vsync_o fell away from an hsync_o fall");
			fail_count++;
		end

	// no colour while either sync pulse is active
	blank_in_sync: assert property (@(posedge pixel_clk) disable iff (rst)
		(!hsync_i || !vsync_i) |-> {red_i, green_i, blue_i} == 8'h00)
		else begin
			$error("rgb is not black during a sync pulse");
			fail_count++;
		end

endmodule

bind arena_display arena_display_assertions sync_check_inst (
	.pixel_clk (pixel_clk),
	.rst       (rst),
	.hsync_i   (hsync_o),
	.vsync_i   (vsync_o),
	.red_i     (red_o),
	.green_i   (green_o),
	.blue_i    (blue_o)
);

/* dv/arena_display_tb.sv */
`timescale 1ns/1ps

module arena_display_tb;

	localparam int H_TOT = 800; // pixels per line
	localparam int V_TOT = 521; // lines per frame
	localparam int H_BEG = 144; // first active column
	localparam int V_BEG = 31;  // first active line

	// model pixel classes, index into the colour table
	localparam int C_BLANK  = 0;
	localparam int C_BG     = 1; // bombs follow as C_BG + level
	localparam int C_P1     = 5;
	localparam int C_P2     = 6;
	localparam int C_BRICK  = 7;
	localparam int C_MORTAR = 8;

	// r3 g3 b2 per class
	localparam logic [7:0] RGB_TABLE [0:8] = '{8'b000_000_00, 8'b111_111_11,
		8'b101_001_11, 8'b100_000_11, 8'b111_000_00, 8'b000_111_00,
		8'b000_000_11, 8'b110_010_00, 8'b000_000_00};

	string class_name [0:8] = '{"blank", "background", "bomb1", "bomb2", "bomb3",
		"player1", "player2", "brick", "mortar"};
	int    mortar_cols [0:5] = '{0, 13, 26, 39, 52, 63};
	int    mortar_rows [0:5] = '{0, 9, 19, 29, 39, 47};
	int    seen [0:8] = '{default: 0}; // pixels checked per class

	logic        pixel_clk;
	logic        rst;
	logic [99:0] arena;
	logic [99:0] bomb_bit0;
	logic [99:0] bomb_bit1;
	logic [3:0]  p1_row;
	logic [3:0]  p1_col;
	logic [3:0]  p2_row;
	logic [3:0]  p2_col;
	logic        hsync;
	logic        vsync;
	logic [2:0]  red;
	logic [2:0]  green;
	logic [1:0]  blue;

	always #5 pixel_clk = ~pixel_clk; // 100 MHz sim clock, period is nominal

	arena_display arena_display_inst (
		.pixel_clk     (pixel_clk),
		.rst           (rst),
		.arena_i       (arena),
		.bomb_bit0_i   (bomb_bit0),
		.bomb_bit1_i   (bomb_bit1),
		.player1_row_i (p1_row),
		.player1_col_i (p1_col),
		.player2_row_i (p2_row),
		.player2_col_i (p2_col),
		.hsync_o       (hsync),
		.vsync_o       (vsync),
		.red_o         (red),
		.green_o       (green),
		.blue_o        (blue)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// sync timing and blanking run in the bound module
	always @(negedge pixel_clk) begin
		if (arena_display_inst.sync_check_inst.fail_count != 0)
			report_failure("a bound sync or blanking assertion failed");
	end

	// returns at the negedge where the sync is first seen low
	task automatic wait_sync_fall(input bit vertical, input int limit);
		logic prev;
		logic cur;
		bit   found;
		prev  = vertical ? vsync : hsync;
		found = 0;
		for (int n = 0; n < limit && !found; n++) begin
			@(negedge pixel_clk);
			cur   = vertical ? vsync : hsync;
			found = prev && !cur;
			prev  = cur;
		end
		if (!found)
			report_failure($sformatf("timeout: %s never fell within %0d cycles",
				vertical ? "vsync_o" : "hsync_o", limit));
	endtask

	task automatic set_cell(input int idx, input bit block, input logic [1:0] lvl);
		arena[idx] = block;
		{bomb_bit1[idx], bomb_bit0[idx]} = lvl;
	endtask

	////////////////////////////////////////
	// grid stimulus
	////////////////////////////////////////
	task automatic fill_grid();
		for (int i = 0; i < 100; i++) begin
			arena[i] = (($urandom % 4) == 0); // about one block in four
			{bomb_bit1[i], bomb_bit0[i]} = 2'($urandom % 4);
		end
		set_cell(23, 1, 2'd0); // player 1 stands on a block
		set_cell(67, 0, 2'd0); // player 2 on open floor
		set_cell(14, 1, 2'd0); // uncovered block
		set_cell(41, 0, 2'd1);
		set_cell(52, 0, 2'd2);
		set_cell(85, 0, 2'd3);
		set_cell(90, 0, 2'd0); // plain background
		p1_row = 4'd2;
		p1_col = 4'd3;
		p2_row = 4'd6;
		p2_col = 4'd7;
	endtask

	// class of the pixel at counter (p, l), first match wins
	function automatic int model_class(input int p, input int l);
		int x;
		int y;
		int row;
		int col;
		int idx;
		bit mortar;
		if (p < H_BEG || p >= H_BEG + 640 || l < V_BEG || l >= V_BEG + 480)
			return C_BLANK;
		x   = p - H_BEG;
		y   = l - V_BEG;
		col = x / 64;
		row = y / 48;
		idx = row * 10 + col;
		if (row == p1_row && col == p1_col)
			return C_P1;
		if (row == p2_row && col == p2_col)
			return C_P2;
		if (arena[idx]) begin
			mortar = 0;
			foreach (mortar_cols[i]) begin
				if (x % 64 == mortar_cols[i] || y % 48 == mortar_rows[i])
					mortar = 1; // joint line
			end
			return mortar ? C_MORTAR : C_BRICK;
		end
		return C_BG + int'({bomb_bit1[idx], bomb_bit0[idx]});
	endfunction

	task automatic check_pixel(input int p, input int l);
		int         cls;
		logic [7:0] exp_rgb;
		cls     = model_class(p, l);
		exp_rgb = RGB_TABLE[cls];
		seen[cls]++;
		assert ({red, green, blue} == exp_rgb) else
			report_failure($sformatf("CHECK FAILED: %s at (%0d,%0d) expected %h actual %h",
				class_name[cls], p, l, exp_rgb, {red, green, blue}));
		assert (hsync == (p >= 96)) else
			report_failure($sformatf("CHECK FAILED: hsync at (%0d,%0d) expected %b actual %b",
				p, l, (p >= 96), hsync));
		assert (vsync == (l >= 2)) else
			report_failure($sformatf("CHECK FAILED: vsync at (%0d,%0d) expected %b actual %b",
				p, l, (l >= 2), vsync));
	endtask

	// one frame from (0,0), player 2 joins player 1 in the bottom blanking
	task automatic check_frame(input bit move_players);
		for (int l = 0; l < V_TOT; l++) begin
			if (l != 0)
				wait_sync_fall(0, 1000);
			for (int p = 0; p < H_TOT; p++) begin
				if (p != 0) begin
					if (move_players && l == V_TOT - 2 && p == 1) begin
						@(posedge pixel_clk);
						#1;
						p2_row = p1_row;
						p2_col = p1_col;
					end
					@(negedge pixel_clk);
				end
				check_pixel(p, l);
			end
		end
	endtask

	initial begin
		pixel_clk   = 1'b0;
		rst         = 1'b1;
		arena       = '0;
		bomb_bit0   = '0;
		bomb_bit1   = '0;
		p1_row      = '0;
		p1_col      = '0;
		p2_row      = '0;
		p2_col      = '0;
		void'($urandom(5582));
		@(posedge pixel_clk);
		#1;
		fill_grid();
		repeat (15) @(posedge pixel_clk); // 16 cycles of reset in total
		#1;
		rst = 1'b0;
		wait_sync_fall(1, 420000);
		check_frame(1);
		wait_sync_fall(1, 420000);
		check_frame(0); // both players on one cell
		foreach (seen[c]) begin
			assert (seen[c] > 0) else
				report_failure($sformatf("no %s pixel was ever displayed", class_name[c]));
		end
		if (arena_display_inst.sync_check_inst.fail_count == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			report_failure("a bound sync or blanking assertion failed");
		end
	end

endmodule

/* arena_display.f */
hdl/arena_pkg.sv
hdl/vga_sync_gen.sv
hdl/grid_locator.sv
hdl/tile_classifier.sv
hdl/color_palette.sv
hdl/arena_display.sv
dv/arena_display_assertions.sv
dv/arena_display_tb.sv
